/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cholesky
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/cholesky_props.sv */
`timescale 1ns/1ps

module cholesky_props
    import chol_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             a_valid,
    input logic             a_ready,
    input logic [MAT_W-1:0] l,
    input logic             l_valid
);

    logic in_flight;                                  // Accepted matrix not yet returned
    int   failures = 0;                               // Failed assertions so far

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (a_valid && a_ready) begin
            in_flight <= 1'b1;
        end else if (l_valid) begin
            in_flight <= 1'b0;
        end
    end

    // ========================================
    // Top-level handshake rules

    valid_single_cycle: assert property (@(posedge clk) disable iff (rst)
        l_valid |=> !l_valid)
        else begin
            failures++;
            $error("l_valid stayed high for two cycles");
        end

    ready_low_while_busy: assert property (@(posedge clk) disable iff (rst)
        (in_flight && !l_valid) |-> !a_ready)
        else begin
            failures++;
            $error("a_ready high between accept and l_valid");
        end

    result_stable_when_idle: assert property (@(posedge clk) disable iff (rst)
        (a_ready && !a_valid) |=> $stable(l))
        else begin
            failures++;
            $error("l changed while the DUT was idle");
        end

endmodule

bind cholesky_top cholesky_props cholesky_props_inst (
    .clk     (clk),
    .rst     (rst),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .l       (l),
    .l_valid (l_valid)
);

/* testbench/tb_cholesky.sv */
`timescale 1ns/1ps

module tb_cholesky
    import chol_pkg::*;
;

    localparam int SEED           = 34816;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int HOLD_CYCLES    = 100;          // Well short of one factorisation

    logic             clk;
    logic             rst;
    logic [MAT_W-1:0] a;
    logic             a_valid;
    logic             a_ready;
    logic [MAT_W-1:0] l;
    logic             l_valid;

    int errors   = 0;
    int timeouts = 0;

    tb_clock tb_clock_inst (
        .clk (clk)
    );

    cholesky_top cholesky_top_inst (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .l       (l),
        .l_valid (l_valid)
    );

    // ========================================
    // Integer model of the factorisation

    function automatic int word_at(input int i, input int j);
        return i * (i + 1) / 2 + j;                   // Row by row packing
    endfunction

    function automatic int elem(input logic [MAT_W-1:0] m, input int i, input int j);
        return int'(m[word_at(i, j)*WORD_W +: WORD_W]);
    endfunction

    function automatic longint floor_sqrt(input longint v);
        longint x;
        longint t;
        x = 0;
        for (int b = 23; b >= 0; b--) begin
            t = x | (longint'(1) << b);
            if (t * t <= v) begin
                x = t;
            end
        end
        return x;
    endfunction

    function automatic logic [MAT_W-1:0] expected_factor(input logic [MAT_W-1:0] am);
        int               lw [ELEMS];
        logic [MAT_W-1:0] lf;
        longint           sum;
        longint           scaled;
        int               resid;
        for (int e = 0; e < ELEMS; e++) begin
            lw[e] = 0;
        end
        for (int j = 0; j < N; j++) begin
            for (int i = j; i < N; i++) begin
                sum = 0;
                for (int k = 0; k < j; k++) begin
                    sum += longint'(lw[word_at(i, k)]) * longint'(lw[word_at(j, k)]);
                end
                resid  = elem(am, i, j) - int'(sum >>> FRAC_BITS);  // Bits 47:16
                scaled = longint'(resid) <<< FRAC_BITS;
                if (i == j) begin
                    lw[word_at(i, j)] = (resid < 0) ? 0 : int'(floor_sqrt(scaled));
                end else begin
                    lw[word_at(i, j)] = int'(scaled / longint'(lw[word_at(j, j)]));
                end
            end
        end
        lf = '0;
        for (int e = 0; e < ELEMS; e++) begin
            lf[e*WORD_W +: WORD_W] = lw[e];
        end
        return lf;
    endfunction

    // Lower triangle of L times its transpose, Q16.16
    function automatic logic [MAT_W-1:0] product_lower(input logic [MAT_W-1:0] lf);
        logic [MAT_W-1:0] am;
        longint           sum;
        am = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                sum = 0;
                for (int k = 0; k <= j; k++) begin
                    sum += longint'(elem(lf, i, k)) * longint'(elem(lf, j, k));
                end
                am[word_at(i, j)*WORD_W +: WORD_W] = 32'(sum >>> FRAC_BITS);
            end
        end
        return am;
    endfunction

    function automatic logic [MAT_W-1:0] random_factor();
        logic [MAT_W-1:0] lf;
        int               v;
        lf = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                if (i == j) begin
                    v = 65536 + int'($urandom_range(196607, 0));      // 1.0 up to 4.0
                end else begin
                    v = int'($urandom_range(262143, 0)) - 131072;     // -2.0 up to 2.0
                end
                lf[word_at(i, j)*WORD_W +: WORD_W] = v;
            end
        end
        return lf;
    endfunction

    // ========================================
    // Driving and checking

    task automatic apply_reset();
        rst     = 1'b1;
        a_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic apply_matrix(input logic [MAT_W-1:0] am);
        bit ready_seen;
        ready_seen = 1'b0;
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            @(negedge clk);
            if (a_ready) begin
                ready_seen = 1'b1;
                break;
            end
        end
        if (!ready_seen) begin
            timeouts++;
            $display("Timeout: the DUT never became ready for a new matrix");
        end
        @(posedge clk);
        #1;
        a       = am;
        a_valid = 1'b1;
        @(posedge clk);                               // Accept edge
        #1 a_valid = 1'b0;
    endtask

    task automatic wait_result(output bit got);
        got = 1'b0;
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            @(negedge clk);
            if (l_valid) begin
                got = 1'b1;
                break;
            end
        end
        if (!got) begin
            timeouts++;
            $display("Timeout: no result arrived within %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    task automatic check_factor(input string name, input logic [MAT_W-1:0] exp);
        int got_w;
        int exp_w;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                got_w = elem(l, i, j);
                exp_w = elem(exp, i, j);
                assert (got_w == exp_w) else begin
                    errors++;
                    $display("ERROR at %0t: %s L(%0d,%0d) is %h, expected %h",
                             $time, name, i, j, got_w, exp_w);
                end
            end
        end
    endtask

    task automatic check_idle_outputs(input string name);
        assert (a_ready && !l_valid && l == '0) else begin
            errors++;
            $display("ERROR at %0t: %s a_ready=%b l_valid=%b l_zero=%b",
                     $time, name, a_ready, l_valid, l == '0);
        end
    endtask

    task automatic run_case(input string name, input logic [MAT_W-1:0] am,
                            input logic [MAT_W-1:0] exp);
        bit got;
        apply_matrix(am);
        wait_result(got);
        if (got) begin
            check_factor(name, exp);
        end
    endtask

    // ========================================
    // Directed tests

    task automatic reset_and_identity();
        logic [MAT_W-1:0] ident;
        ident = '0;
        for (int i = 0; i < N; i++) begin
            ident[word_at(i, i)*WORD_W +: WORD_W] = 32'h0001_0000;
        end
        apply_reset();
        @(negedge clk);
        check_idle_outputs("after reset");
        run_case("identity", ident, ident);
    endtask

    task automatic perfect_square_diagonal();
        logic [MAT_W-1:0] am;
        logic [MAT_W-1:0] exp;
        am  = '0;
        exp = '0;
        for (int i = 0; i < N; i++) begin
            am[word_at(i, i)*WORD_W +: WORD_W]  = 32'((i + 1) * (i + 1) * 65536);
            exp[word_at(i, i)*WORD_W +: WORD_W] = 32'((i + 1) * 65536);
        end
        run_case("square diagonal", am, exp);
    endtask

    task automatic known_integer_factor();
        int               known [ELEMS] = '{2, -1, 3, 1, 2, 2, 3, -2, 1, 1, -2, 1, -3, 2, 4};
        logic [MAT_W-1:0] lf;
        lf = '0;
        for (int e = 0; e < ELEMS; e++) begin
            lf[e*WORD_W +: WORD_W] = 32'(known[e] * 65536);
        end
        run_case("integer factor", product_lower(lf), lf);
    endtask

    task automatic random_matrices();
        logic [MAT_W-1:0] am;
        for (int n = 0; n < 10; n++) begin
            am = product_lower(random_factor());
            run_case($sformatf("random %0d", n), am, expected_factor(am));
        end
    endtask

    task automatic held_valid_ignored();
        logic [MAT_W-1:0] first_a;
        logic [MAT_W-1:0] second_a;
        logic [MAT_W-1:0] held_l;
        bit               got;
        first_a  = product_lower(random_factor());
        second_a = product_lower(random_factor());
        apply_matrix(first_a);
        a       = second_a;                           // Offered while busy
        a_valid = 1'b1;
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            @(negedge clk);
            assert (!a_ready) else begin
                errors++;
                $display("ERROR at %0t: a_ready high during a computation", $time);
            end
        end
        @(posedge clk);
        #1 a_valid = 1'b0;
        wait_result(got);
        if (got) begin
            check_factor("first of two", expected_factor(first_a));
        end
        held_l = l;
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            assert (a_ready && l == held_l) else begin
                errors++;
                $display("ERROR at %0t: result not held while idle", $time);
            end
        end
        apply_matrix(second_a);
        @(negedge clk);
        assert (l == '0) else begin
            errors++;
            $display("ERROR at %0t: l not cleared after the accept", $time);
        end
        wait_result(got);
        if (got) begin
            check_factor("second of two", expected_factor(second_a));
        end
    endtask

    task automatic reset_during_factor();
        logic [MAT_W-1:0] am;
        apply_matrix(product_lower(random_factor()));
        repeat (60) @(posedge clk);
        #1;
        apply_reset();
        @(negedge clk);
        check_idle_outputs("after mid-run reset");
        am = product_lower(random_factor());
        run_case("after reset", am, expected_factor(am));
    endtask

    // ========================================
    // Run

    initial begin
        rst     = 1'b1;
        a       = '0;
        a_valid = 1'b0;
        void'($urandom(SEED));

        reset_and_identity();
        perfect_square_diagonal();
        known_integer_factor();
        random_matrices();
        held_valid_ignored();
        reset_during_factor();

        $display("Failed checks: %0d, failed assertions: %0d, timeouts: %0d",
                 errors, cholesky_top_inst.cholesky_props_inst.failures, timeouts);
        if (errors == 0 && timeouts == 0 &&
            cholesky_top_inst.cholesky_props_inst.failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* verilog.f */
verilog/chol_pkg.sv
verilog/fixed_sqrt.sv
verilog/fixed_div.sv
verilog/residual_mac.sv
verilog/factor_store.sv
verilog/chol_sequencer.sv
verilog/cholesky_top.sv
testbench/tb_clock.sv
testbench/cholesky_props.sv
testbench/tb_cholesky.sv

/* verilog/chol_pkg.sv */
package chol_pkg;

    // ========================================
    // Matrix and number format

    localparam int N         = 5;                 // Matrix order
    localparam int FRAC_BITS = 16;                // Q16.16
    localparam int WORD_W    = 32;
    localparam int ACC_W     = 64;                // Full product sum
    localparam int ELEMS     = N * (N + 1) / 2;   // Lower triangle words
    localparam int MAT_W     = ELEMS * WORD_W;
    localparam int IDX_W     = $clog2(ELEMS);
    localparam int ROW_W     = $clog2(N);

    // ========================================
    // Sequencer state codes

    localparam int STATE_W = 3;

    localparam logic [STATE_W-1:0] S_IDLE   = 3'd0;
    localparam logic [STATE_W-1:0] S_RESID  = 3'd1;
    localparam logic [STATE_W-1:0] S_ROOT   = 3'd2;
    localparam logic [STATE_W-1:0] S_DIVIDE = 3'd3;
    localparam logic [STATE_W-1:0] S_FINISH = 3'd4;

    // Word index of element (row, col) in the row-by-row packing
    function automatic logic [IDX_W-1:0] tri_index(input logic [ROW_W-1:0] row,
                                                   input logic [ROW_W-1:0] col);
        int r;
        r = int'(row);
        return IDX_W'(r * (r + 1) / 2 + int'(col));
    endfunction

endpackage

/* verilog/chol_sequencer.sv */
`timescale 1ns/1ps

module chol_sequencer
    import chol_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              a_valid,
    output logic              a_ready,
    output logic              load,
    output logic [ROW_W-1:0]  row,
    output logic [ROW_W-1:0]  col,
    output logic [IDX_W-1:0]  a_idx,
    output logic              mac_start,
    input  logic              mac_done,
    input  logic [WORD_W-1:0] residual,
    output logic              sqrt_req,
    input  logic              sqrt_ack,
    input  logic [WORD_W-1:0] root,
    output logic              div_req,
    input  logic              div_ack,
    input  logic [WORD_W-1:0] quotient,
    output logic              wr_en,
    output logic [IDX_W-1:0]  wr_idx,
    output logic [WORD_W-1:0] wr_data,
    output logic              l_valid
);

    logic [STATE_W-1:0] state;
    logic               on_diag;
    logic               zero_elem;
    logic               elem_done;

    assign a_ready = (state == S_IDLE);
    assign load    = a_ready && a_valid;              // Capture A on the accept edge
    assign a_idx   = tri_index(row, col);
    assign on_diag = (row == col);

    // Zero residual below the diagonal gives a zero element without a divide
    assign zero_elem = (state == S_RESID) && mac_done && !on_diag && (residual == '0);

    assign elem_done = ((state == S_ROOT) && sqrt_req && sqrt_ack) ||
                       ((state == S_DIVIDE) && div_req && div_ack) ||
                       zero_elem;

    // ========================================
    // Store write port

    assign wr_en  = elem_done;
    assign wr_idx = a_idx;

    always_comb begin
        case (state)
            S_ROOT:   wr_data = root;
            S_DIVIDE: wr_data = quotient;
            default:  wr_data = '0;
        endcase
    end

    // ========================================
    // Column and row walk

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            row       <= '0;
            col       <= '0;
            mac_start <= 1'b0;
            sqrt_req  <= 1'b0;
            div_req   <= 1'b0;
            l_valid   <= 1'b0;
        end else begin
            mac_start <= 1'b0;
            l_valid   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (a_valid) begin
                        row       <= '0;
                        col       <= '0;
                        mac_start <= 1'b1;             // L(0,0) needs no products
                        state     <= S_RESID;
                    end
                end
                S_RESID: begin
                    if (mac_done && !zero_elem) begin
                        state <= on_diag ? S_ROOT : S_DIVIDE;
                    end
                end
                S_ROOT: begin
                    if (!sqrt_req && !sqrt_ack) begin
                        sqrt_req <= 1'b1;
                    end
                end
                S_DIVIDE: begin
                    if (!div_req && !div_ack) begin
                        div_req <= 1'b1;
                    end
                end
                S_FINISH: begin
                    l_valid <= 1'b1;                   // L(4,4) is in the store now
                    state   <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase

            if (elem_done) begin
                sqrt_req <= 1'b0;
                div_req  <= 1'b0;
                if (row == ROW_W'(N - 1)) begin
                    if (col == ROW_W'(N - 1)) begin
                        state <= S_FINISH;
                    end else begin
                        col       <= col + 1'b1;       // Next diagonal
                        row       <= col + 1'b1;
                        mac_start <= 1'b1;
                        state     <= S_RESID;
                    end
                end else begin
                    row       <= row + 1'b1;
                    mac_start <= 1'b1;
                    state     <= S_RESID;
                end
            end
        end
    end

endmodule

/* verilog/cholesky_top.sv */
`timescale 1ns/1ps

module cholesky_top
    import chol_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [MAT_W-1:0] a,
    input  logic             a_valid,
    output logic             a_ready,
    output logic [MAT_W-1:0] l,
    output logic             l_valid
);

    logic              load;
    logic [ROW_W-1:0]  row;
    logic [ROW_W-1:0]  col;
    logic [IDX_W-1:0]  a_idx;
    logic [WORD_W-1:0] a_elem;
    logic              mac_start;
    logic              mac_done;
    logic [WORD_W-1:0] residual;
    logic [IDX_W-1:0]  rd_idx_a;
    logic [WORD_W-1:0] rd_data_a;
    logic [IDX_W-1:0]  rd_idx_b;
    logic [WORD_W-1:0] rd_data_b;
    logic              sqrt_req;
    logic              sqrt_ack;
    logic [WORD_W-1:0] root;
    logic              div_req;
    logic              div_ack;
    logic [WORD_W-1:0] quotient;
    logic              wr_en;
    logic [IDX_W-1:0]  wr_idx;
    logic [WORD_W-1:0] wr_data;

    factor_store factor_store_inst (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .a         (a),
        .a_idx     (a_idx),
        .a_elem    (a_elem),
        .rd_idx_a  (rd_idx_a),
        .rd_data_a (rd_data_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .l         (l)
    );

    chol_sequencer chol_sequencer_inst (
        .clk       (clk),
        .rst       (rst),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .load      (load),
        .row       (row),
        .col       (col),
        .a_idx     (a_idx),
        .mac_start (mac_start),
        .mac_done  (mac_done),
        .residual  (residual),
        .sqrt_req  (sqrt_req),
        .sqrt_ack  (sqrt_ack),
        .root      (root),
        .div_req   (div_req),
        .div_ack   (div_ack),
        .quotient  (quotient),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .l_valid   (l_valid)
    );

    residual_mac residual_mac_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (mac_start),
        .row       (row),
        .col       (col),
        .a_elem    (a_elem),
        .rd_idx_a  (rd_idx_a),
        .rd_data_a (rd_data_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_b (rd_data_b),
        .done      (mac_done),
        .residual  (residual)
    );

    fixed_sqrt fixed_sqrt_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (sqrt_req),
        .radicand (residual),
        .ack      (sqrt_ack),
        .root     (root)
    );

    // Root holds the column diagonal until the next diagonal is requested
    fixed_div fixed_div_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (div_req),
        .dividend (residual),
        .divisor  (root),
        .ack      (div_ack),
        .quotient (quotient)
    );

endmodule

/* verilog/factor_store.sv */
`timescale 1ns/1ps

module factor_store
    import chol_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic [MAT_W-1:0]  a,
    input  logic [IDX_W-1:0]  a_idx,
    output logic [WORD_W-1:0] a_elem,
    input  logic [IDX_W-1:0]  rd_idx_a,
    output logic [WORD_W-1:0] rd_data_a,
    input  logic [IDX_W-1:0]  rd_idx_b,
    output logic [WORD_W-1:0] rd_data_b,
    input  logic              wr_en,
    input  logic [IDX_W-1:0]  wr_idx,
    input  logic [WORD_W-1:0] wr_data,
    output logic [MAT_W-1:0]  l
);

    logic [WORD_W-1:0] a_mem [ELEMS];
    logic [WORD_W-1:0] l_mem [ELEMS];

    always_ff @(posedge clk) begin
        if (load) begin
            for (int e = 0; e < ELEMS; e++) begin
                a_mem[e] <= a[e*WORD_W +: WORD_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || load) begin
            for (int e = 0; e < ELEMS; e++) begin
                l_mem[e] <= '0;                       // Fresh factor per matrix
            end
        end else if (wr_en) begin
            l_mem[wr_idx] <= wr_data;
        end
    end

    assign a_elem    = a_mem[a_idx];
    assign rd_data_a = l_mem[rd_idx_a];
    assign rd_data_b = l_mem[rd_idx_b];

    // Output keeps the input's row-by-row packing
    always_comb begin
        logic [IDX_W-1:0] e;
        l = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                e = tri_index(ROW_W'(i), ROW_W'(j));
                l[e*WORD_W +: WORD_W] = l_mem[e];
            end
        end
    end

endmodule

/* verilog/fixed_div.sv */
`timescale 1ns/1ps

module fixed_div
    import chol_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  logic [WORD_W-1:0] dividend,
    input  logic [WORD_W-1:0] divisor,
    output logic              ack,
    output logic [WORD_W-1:0] quotient
);

    logic                                  busy;
    logic [$clog2(WORD_W+FRAC_BITS)-1:0]   step;
    logic [WORD_W+FRAC_BITS-1:0]           work;     // Numerator out the top, quotient in
    logic [WORD_W-1:0]                     rem;
    logic [WORD_W-1:0]                     dsr;
    logic                                  neg;
    logic [WORD_W:0]                       rem_sh;
    logic [WORD_W-1:0]                     mag;

    always_comb begin
        rem_sh = {rem, work[WORD_W+FRAC_BITS-1]};
        mag    = dividend[WORD_W-1] ? -dividend : dividend;
    end

    // Handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            ack  <= 1'b0;
            step <= '0;
        end else if (!busy && !ack) begin
            if (req) begin
                busy <= 1'b1;
                step <= '0;
            end
        end else if (busy) begin
            step <= step + 1'b1;
            if (step == WORD_W + FRAC_BITS - 1) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    // ========================================
    // Restoring division of the magnitude

    always_ff @(posedge clk) begin
        if (!busy && !ack && req) begin
            work <= {mag, {FRAC_BITS{1'b0}}};         // Scale by 2^16
            rem  <= '0;
            dsr  <= divisor;                          // Always positive here
            neg  <= dividend[WORD_W-1];
        end else if (busy) begin
            if (rem_sh >= {1'b0, dsr}) begin
                rem  <= rem_sh[WORD_W-1:0] - dsr;
                work <= {work[WORD_W+FRAC_BITS-2:0], 1'b1};
            end else begin
                rem  <= rem_sh[WORD_W-1:0];
                work <= {work[WORD_W+FRAC_BITS-2:0], 1'b0};
            end
        end
    end

    // Sign applied after the magnitude divide, so truncation is toward zero
    assign quotient = neg ? -work[WORD_W-1:0] : work[WORD_W-1:0];

endmodule

/* verilog/fixed_sqrt.sv */
`timescale 1ns/1ps

module fixed_sqrt
    import chol_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  logic [WORD_W-1:0] radicand,
    output logic              ack,
    output logic [WORD_W-1:0] root
);

    logic                                      busy;
    logic [$clog2((WORD_W+FRAC_BITS)/2)-1:0]   step;
    logic [WORD_W+FRAC_BITS-1:0]               op;      // Radicand bits, two per step
    logic [(WORD_W+FRAC_BITS)/2+1:0]           rem;     // Partial remainder
    logic [(WORD_W+FRAC_BITS)/2-1:0]           res;     // Root built MSB first
    logic [(WORD_W+FRAC_BITS)/2+3:0]           rem_sh;
    logic [(WORD_W+FRAC_BITS)/2+3:0]           trial;

    always_comb begin
        rem_sh = {rem, op[WORD_W+FRAC_BITS-1 -: 2]};  // Bring down next digit pair
        trial  = {2'b00, res, 2'b01};                 // 4*root + 1
    end

    // Handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            ack  <= 1'b0;
            step <= '0;
        end else if (!busy && !ack) begin
            if (req) begin
                busy <= 1'b1;
                step <= '0;
            end
        end else if (busy) begin
            step <= step + 1'b1;
            if (step == (WORD_W + FRAC_BITS) / 2 - 1) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end
        end else if (!req) begin
            ack <= 1'b0;                              // Requester has seen the root
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && !ack && req) begin
            // Negative residual maps to a zero root
            op  <= radicand[WORD_W-1] ? '0 : {radicand, {FRAC_BITS{1'b0}}};
            rem <= '0;
            res <= '0;
        end else if (busy) begin
            op <= op << 2;
            if (rem_sh >= trial) begin
                rem <= rem_sh[$bits(rem)-1:0] - trial[$bits(rem)-1:0];
                res <= {res[$bits(res)-2:0], 1'b1};
            end else begin
                rem <= rem_sh[$bits(rem)-1:0];
                res <= {res[$bits(res)-2:0], 1'b0};
            end
        end
    end

    assign root = WORD_W'(res);                       // Floor root, Q16.16

endmodule

/* verilog/residual_mac.sv */
`timescale 1ns/1ps

module residual_mac
    import chol_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [ROW_W-1:0]  row,
    input  logic [ROW_W-1:0]  col,
    input  logic [WORD_W-1:0] a_elem,
    output logic [IDX_W-1:0]  rd_idx_a,
    input  logic [WORD_W-1:0] rd_data_a,
    output logic [IDX_W-1:0]  rd_idx_b,
    input  logic [WORD_W-1:0] rd_data_b,
    output logic              done,
    output logic [WORD_W-1:0] residual
);

    logic                    busy;
    logic [ROW_W-1:0]        row_q;
    logic [ROW_W-1:0]        col_q;
    logic [ROW_W-1:0]        k;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] prod;

    assign rd_idx_a = tri_index(row_q, k);            // L(row,k)
    assign rd_idx_b = tri_index(col_q, k);            // L(col,k)
    assign prod     = ACC_W'($signed(rd_data_a)) * ACC_W'($signed(rd_data_b));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            k    <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                k    <= '0;
            end else if (busy) begin
                if (k == col_q) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    k <= k + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            row_q <= row;
            col_q <= col;
            acc   <= '0;
        end else if (busy) begin
            if (k == col_q) begin
                residual <= a_elem - acc[FRAC_BITS +: WORD_W];  // Bits 47:16 of the sum
            end else begin
                acc <= acc + prod;
            end
        end
    end

endmodule
